/* src.f */
logic/branch_pkg.sv
logic/pipe_reg.sv
logic/branch_cond.sv
logic/branch_target.sv
logic/branch_resolve.sv
logic/branch_exec_stage.sv
+incdir+sim
sim/branch_checker.sv
sim/tb_branch_exec.sv

/* run_sim.sh */
#!/bin/sh
# Builds the branch stage testbench with Verilator and runs it into sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_branch_exec -f src.f \
    -o tb_branch_exec --Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_branch_exec > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

/* sim/branch_model.svh */
// reference model of the branch stage, taken from the branch rules of the core.
function automatic branch_resp_t expected_resp(input branch_req_t r);
    branch_resp_t e;
    word_t        offs16;
    word_t        offs26;
    word_t        target;
    logic         is_br;
    logic         tk;
    offs16 = {{16{r.inst[25]}}, r.inst[25:10]} << 2;
    offs26 = {{6{r.inst[9]}}, r.inst[9:0], r.inst[25:10]} << 2;
    is_br  = 1'b1;
    tk     = 1'b0;
    target = r.pc + offs16;
    case (r.op)
        OP_BEQ:  tk = (r.reg1 == r.reg2);
        OP_BNE:  tk = (r.reg1 != r.reg2);
        OP_BLT:  tk = ($signed(r.reg1) < $signed(r.reg2));
        OP_BGE:  tk = ($signed(r.reg1) >= $signed(r.reg2));
        OP_BLTU: tk = (r.reg1 < r.reg2);
        OP_BGEU: tk = (r.reg1 >= r.reg2);
        OP_B, OP_BL: begin
            tk     = 1'b1;
            target = r.pc + offs26;
        end
        OP_JIRL: begin
            tk     = 1'b1;
            target = r.reg1 + offs16;
        end
        default: begin
            is_br  = 1'b0;
            target = '0;
        end
    endcase
    e.pc           = r.pc;
    e.update_en    = is_br && (r.op != OP_B) && (r.op != OP_BL);
    e.actual_taken = tk;
    if (tk) begin
        e.actual_addr = target;
    end else if (is_br && r.pred_taken) begin
        e.actual_addr = r.pc + 32'd4;
    end else begin
        e.actual_addr = '0;
    end
    e.flush     = is_br && ((tk != r.pred_taken) || (tk && (target != r.pred_addr)));
    e.link_addr = r.pc + 32'd4;
    return e;
endfunction

/* sim/tb_branch_exec.sv */
`timescale 1ns/100ps

module tb_branch_exec
    import branch_pkg::*;
();

    `include "branch_model.svh"

    localparam int KIND_COND = 0;
    localparam int KIND_JUMP = 1;
    localparam int KIND_ANY  = 2;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    logic         req_ready;
    branch_req_t  req;
    logic         resp_valid;
    logic         resp_ready;
    branch_resp_t resp;
    logic         idle_check;
    logic         stream_check;
    int           errors;
    int           pending;
    int           checked;
    int           errors_before;
    logic [31:0]  rng_state;
    bit           timed_out;

    branch_exec_stage dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    branch_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp),
        .idle_check   (idle_check),
        .stream_check (stream_check),
        .errors       (errors),
        .pending      (pending),
        .checked      (checked)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic make_req(input int kind, output branch_req_t r);
        branch_resp_t truth;
        logic [31:0]  sel;
        logic [3:0]   code;
        sel = next_random();
        case (kind)
            KIND_COND: code = 4'(sel % 6) + 4'd1;
            KIND_JUMP: code = 4'(sel % 3) + 4'd7;
            default:   code = 4'(sel % 10);
        endcase
        r.op   = branch_op_t'(code);
        r.pc   = next_random() & 32'hffff_fffc;
        r.inst = next_random();
        r.reg1 = next_random();
        // a quarter of the pairs are equal or differ only in the sign bit.
        sel = next_random() % 8;
        if (sel == 0) begin
            r.reg2 = r.reg1;
        end else if (sel == 1) begin
            r.reg2 = r.reg1 ^ 32'h8000_0000;
        end else begin
            r.reg2 = next_random();
        end
        r.pred_taken = 1'b0;
        r.pred_addr  = '0;
        truth        = expected_resp(r);
        sel          = next_random() % 4;
        if (sel < 2) begin
            r.pred_taken = truth.actual_taken;
            r.pred_addr  = truth.actual_taken ? truth.actual_addr : next_random();
        end else if (sel == 2) begin
            r.pred_taken = !truth.actual_taken;
            r.pred_addr  = next_random();
        end else begin
            // the direction is right but the target is one bit off.
            r.pred_taken = truth.actual_taken;
            r.pred_addr  = truth.actual_addr ^ (32'd1 << (next_random() % 32));
        end
    endtask

    task automatic run_traffic(input int kind, input int valid_pct, input int ready_pct,
                               input int count);
        branch_req_t r;
        int          sent;
        int          ticks;
        bit          loaded;
        sent   = 0;
        ticks  = 0;
        loaded = 1'b0;
        while (sent < count && !timed_out) begin
            @(posedge clk);
            ticks++;
            if (req_valid && req_ready) begin
                sent++;
                loaded = 1'b0;
            end
            if (!loaded && sent < count && (next_random() % 100) < valid_pct) begin
                make_req(kind, r);
                req       <= r;
                req_valid <= 1'b1;
                loaded    = 1'b1;
            end else if (!loaded) begin
                req_valid <= 1'b0;
            end
            resp_ready <= ((next_random() % 100) < ready_pct);
            if (ticks > count * 40) begin
                $display("request traffic stalled with %0d of %0d requests accepted",
                         sent, count);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic drain_responses();
        int ticks;
        ticks = 0;
        @(posedge clk);
        req_valid  <= 1'b0;
        resp_ready <= 1'b1;
        @(negedge clk);
        while (pending != 0 && !timed_out) begin
            @(negedge clk);
            ticks++;
            if (ticks > 50) begin
                $display("responses did not drain, %0d still outstanding", pending);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic report_test(input int num, input string name);
        @(negedge clk);
        if (errors == errors_before && !timed_out) begin
            $display("test %0d %s: ok (%0d errors)", num, name, errors - errors_before);
        end else begin
            $display("test %0d %s: bad (%0d errors)", num, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        rng_state     = 32'h56dd_600c;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        resp_ready    = 1'b0;
        idle_check    = 1'b0;
        stream_check  = 1'b0;
        timed_out     = 1'b0;
        errors_before = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        idle_check <= 1'b1;
        @(posedge clk);
        idle_check <= 1'b0;
        report_test(1, "idle after reset");
        run_traffic(KIND_COND, 70, 60, 300);
        drain_responses();
        report_test(2, "conditional branches");
        run_traffic(KIND_JUMP, 70, 60, 150);
        drain_responses();
        report_test(3, "jumps and links");
        run_traffic(KIND_ANY, 70, 60, 300);
        drain_responses();
        report_test(4, "flush decisions");
        run_traffic(KIND_ANY, 70, 60, 400);
        drain_responses();
        report_test(5, "random back-pressure");
        @(posedge clk);
        stream_check <= 1'b1;
        run_traffic(KIND_ANY, 100, 100, 40);
        drain_responses();
        @(posedge clk);
        stream_check <= 1'b0;
        report_test(6, "back-to-back streaming");
        if (errors == 0 && !timed_out) begin
            $display("%0d responses checked, 0 errors", checked);
            $display("ALL CHECKS PASSED");
        end else begin
            $display("%0d responses checked, %0d errors, timeout %0d", checked, errors,
                     timed_out);
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim/branch_checker.sv */
`timescale 1ns/100ps

module branch_checker
    import branch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req_valid,
    input  logic         req_ready,
    input  branch_req_t  req,
    input  logic         resp_valid,
    input  logic         resp_ready,
    input  branch_resp_t resp,
    input  logic         idle_check,
    input  logic         stream_check,
    output int           errors,
    output int           pending,
    output int           checked
);

    `include "branch_model.svh"

    branch_resp_t expected_q[$];
    int           accept_q[$];
    branch_resp_t exp_resp;
    int           cycle;
    int           accepted_at;

    task automatic compare_field(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            errors++;
            $display("Error: %s got %h expected %h for pc %h", name, got, want, resp.pc);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expected_q.delete();
            accept_q.delete();
            cycle   = 0;
            errors  = 0;
            checked = 0;
            pending = 0;
        end else begin
            if (idle_check && (resp_valid !== 1'b0 || req_ready !== 1'b1)) begin
                errors++;
                $display("stage not idle after reset: resp_valid %b, req_ready %b",
                         resp_valid, req_ready);
            end
            // with the output always taken, the input side must never stall.
            if (stream_check && req_valid && !req_ready) begin
                errors++;
                $display("request stalled in cycle %0d although responses were taken", cycle);
            end
            if (resp_valid && resp_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("response for pc %h arrived with no request outstanding", resp.pc);
                end else begin
                    exp_resp    = expected_q.pop_front();
                    accepted_at = accept_q.pop_front();
                    checked++;
                    compare_field("pc", resp.pc, exp_resp.pc);
                    compare_field("update_en", word_t'(resp.update_en),
                                  word_t'(exp_resp.update_en));
                    compare_field("actual_taken", word_t'(resp.actual_taken),
                                  word_t'(exp_resp.actual_taken));
                    compare_field("actual_addr", resp.actual_addr, exp_resp.actual_addr);
                    compare_field("flush", word_t'(resp.flush), word_t'(exp_resp.flush));
                    compare_field("link_addr", resp.link_addr, exp_resp.link_addr);
                    if (stream_check && (cycle - accepted_at != 2)) begin
                        errors++;
                        $display("response for pc %h took %0d cycles instead of 2",
                                 resp.pc, cycle - accepted_at);
                    end
                end
            end
            if (req_valid && req_ready) begin
                expected_q.push_back(expected_resp(req));
                accept_q.push_back(cycle);
            end
            cycle++;
            pending = expected_q.size();
        end
    end

endmodule

/* logic/branch_exec_stage.sv */
`timescale 1ns/100ps

module branch_exec_stage
    import branch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req_valid,
    output logic         req_ready,
    input  branch_req_t  req,
    output logic         resp_valid,
    input  logic         resp_ready,
    output branch_resp_t resp
);

    branch_req_t  req_q;
    logic         req_q_valid;
    logic         req_q_ready;
    logic         is_branch;
    logic         taken;
    word_t        target_addr;
    word_t        fall_addr;
    branch_resp_t resp_d;

    pipe_reg #(.payload_t(branch_req_t)) u_req_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (req_q_valid),
        .out_ready (req_q_ready),
        .out_data  (req_q)
    );

    branch_cond u_cond (
        .op        (req_q.op),
        .reg1      (req_q.reg1),
        .reg2      (req_q.reg2),
        .is_branch (is_branch),
        .taken     (taken)
    );

    branch_target u_target (
        .op          (req_q.op),
        .pc          (req_q.pc),
        .inst        (req_q.inst),
        .reg1        (req_q.reg1),
        .target_addr (target_addr),
        .fall_addr   (fall_addr)
    );

    branch_resolve u_resolve (
        .req         (req_q),
        .is_branch   (is_branch),
        .taken       (taken),
        .target_addr (target_addr),
        .fall_addr   (fall_addr),
        .resp        (resp_d)
    );

    // the resolved record moves on in the same cycle the stored request is released.
    pipe_reg #(.payload_t(branch_resp_t)) u_resp_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_q_valid),
        .in_ready  (req_q_ready),
        .in_data   (resp_d),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (resp)
    );

endmodule

/* logic/branch_resolve.sv */
`timescale 1ns/100ps

module branch_resolve
    import branch_pkg::*;
(
    input  branch_req_t  req,
    input  logic         is_branch,
    input  logic         taken,
    input  word_t        target_addr,
    input  word_t        fall_addr,
    output branch_resp_t resp
);

    logic flush;
    logic dir_miss;
    logic addr_miss;
    word_t actual_addr;

    assign dir_miss  = (taken != req.pred_taken);
    assign addr_miss = (target_addr != req.pred_addr);

    // a target miss only matters when both sides agree the branch is taken.
    always_comb begin
        if (!is_branch) begin
            flush = 1'b0;
        end else if (dir_miss) begin
            flush = 1'b1;
        end else if (taken) begin
            flush = addr_miss;
        end else begin
            flush = 1'b0;
        end
    end

    // a wrongly predicted taken branch has to steer fetch back to fall-through.
    always_comb begin
        if (is_branch && taken) begin
            actual_addr = target_addr;
        end else if (is_branch && req.pred_taken) begin
            actual_addr = fall_addr;
        end else begin
            actual_addr = '0;
        end
    end

    always_comb begin
        resp.pc           = req.pc;
        // unconditional direct jumps never need training.
        resp.update_en    = is_branch && (req.op != OP_B) && (req.op != OP_BL);
        resp.actual_taken = taken;
        resp.actual_addr  = actual_addr;
        resp.flush        = flush;
        resp.link_addr    = fall_addr;
    end

endmodule

/* logic/branch_target.sv */
`timescale 1ns/100ps

module branch_target
    import branch_pkg::*;
(
    input  branch_op_t op,
    input  word_t      pc,
    input  word_t      inst,
    input  word_t      reg1,
    output word_t      target_addr,
    output word_t      fall_addr
);

    word_t offs16;
    word_t offs26;

    // both offsets count instructions, so they are scaled to bytes here.
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};

    // the long form keeps its upper ten bits in the low end of the word.
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        case (op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                target_addr = pc + offs16;
            end
            OP_B, OP_BL: target_addr = pc + offs26;
            OP_JIRL:     target_addr = reg1 + offs16;
            default:     target_addr = '0;
        endcase
    end

    assign fall_addr = pc + INST_STEP;

endmodule

/* logic/branch_cond.sv */
`timescale 1ns/100ps

module branch_cond
    import branch_pkg::*;
(
    input  branch_op_t op,
    input  word_t      reg1,
    input  word_t      reg2,
    output logic       is_branch,
    output logic       taken
);

    logic [WORD_W:0] diff;
    logic            eq;
    logic            lt_signed;
    logic            lt_unsigned;

    // the extra top bit of the difference is the borrow of the unsigned compare.
    assign diff        = {1'b0, reg1} - {1'b0, reg2};
    assign eq          = (reg1 == reg2);
    assign lt_unsigned = diff[WORD_W];

    // with opposite signs the negative operand is the smaller one.
    assign lt_signed = (reg1[WORD_W-1] ^ reg2[WORD_W-1]) ? reg1[WORD_W-1]
                                                         : diff[WORD_W-1];

    always_comb begin
        is_branch = 1'b1;
        case (op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt_signed;
            OP_BGE:  taken = !lt_signed;
            OP_BLTU: taken = lt_unsigned;
            OP_BGEU: taken = !lt_unsigned;
            OP_B, OP_BL, OP_JIRL: begin
                taken = 1'b1;
            end
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

endmodule

/* logic/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    logic     load;
    payload_t data_q;

    // a full slot can still take a new item in the cycle its content leaves.
    assign in_ready = !full || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

/* logic/branch_pkg.sv */
package branch_pkg;

    // width of a machine word on this core.
    localparam int WORD_W = 32;

    // a sequential instruction is always one word further on.
    localparam logic [WORD_W-1:0] INST_STEP = 32'd4;

    typedef logic [WORD_W-1:0] word_t;

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_BEQ  = 4'd1,
        OP_BNE  = 4'd2,
        OP_BLT  = 4'd3,
        OP_BGE  = 4'd4,
        OP_BLTU = 4'd5,
        OP_BGEU = 4'd6,
        OP_B    = 4'd7,
        OP_BL   = 4'd8,
        OP_JIRL = 4'd9
    } branch_op_t;

    // one branch coming out of decode, with the front end's guess attached.
    typedef struct packed {
        word_t      pc;
        word_t      inst;
        branch_op_t op;
        word_t      reg1;
        word_t      reg2;
        logic       pred_taken;
        word_t      pred_addr;
    } branch_req_t;

    // the predictor update record together with the flush and link results.
    typedef struct packed {
        word_t pc;
        logic  update_en;
        logic  actual_taken;
        word_t actual_addr;
        logic  flush;
        word_t link_addr;
    } branch_resp_t;

endpackage
